//--- rtl/vc_config.svh
// Build-time constants for the valid/credit FIFO
`ifndef VC_CONFIG_SVH
`define VC_CONFIG_SVH

// --------------------
// Storage
// --------------------

// Number of stored words, must be a power of two
`define VC_DEPTH 16

// Payload width in bits
`define VC_WIDTH 8

// --------------------
// Flow control
// --------------------

// Most credits the downstream may have outstanding to the tail
`define VC_MAX_CREDITS 4

// Head input register stage, 1 adds one cycle on the write side
`define VC_REG_INPUT 0

`endif

//--- rtl/vc_pkg.sv
// Package with the payload, address and pointer types of the valid/credit FIFO
`include "vc_config.svh"

package vc_pkg;

  // --------------------
  // Derived sizes
  // --------------------
  localparam int DEPTH       = `VC_DEPTH;
  localparam int ADDR_W      = $clog2(`VC_DEPTH);
  localparam int MAX_CREDITS = `VC_MAX_CREDITS;

  // --------------------
  // Types
  // --------------------

  // One payload word
  typedef logic [`VC_WIDTH-1:0] data_t;

  // Memory address
  typedef logic [ADDR_W-1:0] addr_t;

  // Address plus one wrap bit, also wide enough for the usage count
  typedef logic [ADDR_W:0] ptr_t;

endpackage

//--- rtl/vc_fifo_head.sv
// FIFO write side: credit issue, write pointer, full flag, usage and input stage
module vc_fifo_head
  import vc_pkg::*;
#(
  parameter bit reg_input = 1'b0
)
(
  input  logic  clk,
  input  logic  reset,
  input  logic  c_vld,
  input  data_t c_data,
  input  ptr_t  rdptr,
  output logic  c_cr,
  output logic  wr_en,
  output addr_t wr_addr,
  output data_t wr_data,
  output ptr_t  wrptr,
  output ptr_t  usage
);

  logic  in_vld;
  data_t in_data;
  logic  full;
  ptr_t  nxt_wrptr;
  ptr_t  nxt_usage;
  ptr_t  cissued;
  ptr_t  nxt_cissued;

  // --------------------
  // Input stage
  // --------------------
  generate
    if (reg_input)
    begin : g_reg_input
      logic  r_vld;
      data_t r_data;

      always_ff @(posedge clk)
      begin
        if (reset)
        begin
          r_vld <= 1'b0;
        end
        else
        begin
          r_vld <= c_vld;
        end
      end

      always_ff @(posedge clk)
      begin
        r_data <= c_data;
      end

      assign in_vld  = r_vld;
      assign in_data = r_data;
    end
    else
    begin : g_direct
      // Word goes straight to the memory in the cycle it arrives
      assign in_vld  = c_vld;
      assign in_data = c_data;
    end
  endgenerate

  // --------------------
  // Write pointer
  // --------------------

  // Same address with opposite wrap bits means every slot holds a word
  assign full = (wrptr[ADDR_W-1:0] == rdptr[ADDR_W-1:0])
             && (wrptr[ADDR_W] != rdptr[ADDR_W]);

  assign wr_en   = in_vld && !full;
  assign wr_addr = wrptr[ADDR_W-1:0];
  assign wr_data = in_data;

  assign nxt_wrptr = wr_en ? wrptr + 1'b1 : wrptr;

  // Modulo subtraction is exact because the depth is a power of two
  assign usage     = wrptr - rdptr;
  assign nxt_usage = nxt_wrptr - rdptr;

  // --------------------
  // Credit accounting
  // --------------------

  // Grant adds an outstanding credit, an arriving word uses one up
  always_comb
  begin
    case ({c_cr, in_vld})
      2'b10:   nxt_cissued = cissued + 1'b1;
      2'b01:   nxt_cissued = cissued - 1'b1;
      default: nxt_cissued = cissued;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr   <= '0;
      cissued <= '0;
      c_cr    <= 1'b0;
    end
    else
    begin
      wrptr   <= nxt_wrptr;
      cissued <= nxt_cissued;
      // Next count already holds the pulse now on c_cr, so at most depth-1 go out
      c_cr    <= (int'(nxt_cissued) + int'(nxt_usage)) < (DEPTH - 1);
    end
  end

endmodule

//--- rtl/vc_fifo_mem.sv
// FIFO storage array with clocked write port and combinational read port
module vc_fifo_mem
  import vc_pkg::*;
(
  input  logic  clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  addr_t rd_addr,
  output data_t rd_data
);

  // --------------------
  // Storage
  // --------------------
  data_t mem [DEPTH];

  // Write lands at the edge where wr_en is high
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // --------------------
  // Read
  // --------------------

  // No read latency, the tail registers the word itself
  assign rd_data = mem[rd_addr];

endmodule

//--- rtl/vc_fifo_tail.sv
// FIFO read side: downstream credit count, read pointer and registered output
module vc_fifo_tail
  import vc_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  ptr_t  wrptr,
  input  data_t rd_data,
  input  logic  p_cr,
  output addr_t rd_addr,
  output ptr_t  rdptr,
  output logic  p_vld,
  output data_t p_data
);

  // Counter wide enough to hold every credit the downstream may grant
  localparam int CR_W = $clog2(MAX_CREDITS + 1);

  logic            empty;
  logic            send;
  logic [CR_W-1:0] credits;
  logic [CR_W-1:0] nxt_credits;

  // --------------------
  // Read decision
  // --------------------

  // Equal pointers including the wrap bit means nothing is stored
  assign empty   = (rdptr == wrptr);
  assign send    = !empty && (credits != '0);
  assign rd_addr = rdptr[ADDR_W-1:0];

  // --------------------
  // Downstream credits
  // --------------------

  // Grant and send in one cycle cancel out
  always_comb
  begin
    case ({p_cr, send})
      2'b10:   nxt_credits = credits + 1'b1;
      2'b01:   nxt_credits = credits - 1'b1;
      default: nxt_credits = credits;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      credits <= '0;
      rdptr   <= '0;
      p_vld   <= 1'b0;
    end
    else
    begin
      credits <= nxt_credits;
      p_vld   <= send;
      if (send)
      begin
        rdptr <= rdptr + 1'b1;
      end
    end
  end

  // --------------------
  // Output word
  // --------------------

  // Only loaded when a word leaves, p_vld qualifies it
  always_ff @(posedge clk)
  begin
    if (send)
    begin
      p_data <= rd_data;
    end
  end

endmodule

//--- rtl/vc_fifo.sv
// Valid/credit FIFO top level joining write side, storage and read side
`include "vc_config.svh"

module vc_fifo
  import vc_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  c_vld,
  input  data_t c_data,
  input  logic  p_cr,
  output logic  c_cr,
  output logic  p_vld,
  output data_t p_data,
  output ptr_t  usage
);

  // Write side to storage
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;

  // Storage to read side
  addr_t rd_addr;
  data_t rd_data;

  // Pointers crossing between head and tail
  ptr_t  wrptr;
  ptr_t  rdptr;

  // --------------------
  // Write side
  // --------------------
  vc_fifo_head #(
    .reg_input (`VC_REG_INPUT)
  ) i_head (
    .clk     (clk),
    .reset   (reset),
    .c_vld   (c_vld),
    .c_data  (c_data),
    .rdptr   (rdptr),
    .c_cr    (c_cr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wrptr   (wrptr),
    .usage   (usage)
  );

  // --------------------
  // Storage
  // --------------------
  vc_fifo_mem i_mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // --------------------
  // Read side
  // --------------------
  vc_fifo_tail i_tail (
    .clk     (clk),
    .reset   (reset),
    .wrptr   (wrptr),
    .rd_data (rd_data),
    .p_cr    (p_cr),
    .rd_addr (rd_addr),
    .rdptr   (rdptr),
    .p_vld   (p_vld),
    .p_data  (p_data)
  );

endmodule

//--- sim/vc_fifo_properties.sv
// Bound assertions on the upstream and downstream credit rules and on FIFO overflow
`include "vc_config.svh"

module vc_fifo_properties
  import vc_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic c_vld,
  input logic c_cr,
  input logic p_cr,
  input logic p_vld,
  input logic wr_en,
  input ptr_t wrptr,
  input ptr_t rdptr
);

  int   up_credits;
  int   dn_credits;
  logic full;
  logic c_vld_d;
  logic arriving;

  // --------------------
  // Credit tracking
  // --------------------

  // Credits counted at the edge where the pulse is seen, spent with each word
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      up_credits <= 0;
      dn_credits <= 0;
      c_vld_d    <= 1'b0;
    end
    else
    begin
      up_credits <= up_credits + int'(c_cr) - int'(c_vld);
      dn_credits <= dn_credits + int'(p_cr) - int'(p_vld);
      c_vld_d    <= c_vld;
    end
  end

  assign full = (wrptr[ADDR_W-1:0] == rdptr[ADDR_W-1:0])
             && (wrptr[ADDR_W] != rdptr[ADDR_W]);

  // Word reaching the write port, one cycle late behind the input register
  assign arriving = (`VC_REG_INPUT != 0) ? c_vld_d : c_vld;

  // --------------------
  // Rules
  // --------------------
  a_upstream_credit: assert property (@(posedge clk) disable iff (reset)
    c_vld |-> (up_credits != 0))
    else $error("c_vld raised while the upstream held no credit");

  a_downstream_credit: assert property (@(posedge clk) disable iff (reset)
    p_vld |-> (dn_credits != 0))
    else $error("p_vld raised while the tail held no credit");

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    arriving |-> (wr_en && !full))
    else $error("word arrived at a full FIFO and was not written");

endmodule

bind vc_fifo vc_fifo_properties i_properties (
  .clk   (clk),
  .reset (reset),
  .c_vld (c_vld),
  .c_cr  (c_cr),
  .p_cr  (p_cr),
  .p_vld (p_vld),
  .wr_en (wr_en),
  .wrptr (wrptr),
  .rdptr (rdptr)
);

//--- sim/tb_vc_fifo.sv
// Testbench for the valid/credit FIFO: clock, reset, LFSR, traffic models, reference and checks
`include "vc_config.svh"

module tb_vc_fifo
  import vc_pkg::*;
();

  localparam int WAIT_LIMIT  = 5000;
  localparam int QUIET_LEN   = 20;
  localparam int ORDER_WORDS = 200;
  localparam int GRANT_WORDS = 5;

  // Counters that wait_for_count can watch
  localparam int SEL_SENT     = 0;
  localparam int SEL_RECEIVED = 1;
  localparam int SEL_USAGE    = 2;

  // Downstream behavior
  localparam int DN_OFF     = 0;
  localparam int DN_RANDOM  = 1;
  localparam int DN_COUNTED = 2;

  logic  clk    = 1'b0;
  logic  reset  = 1'b1;
  logic  c_vld  = 1'b0;
  data_t c_data = '0;
  logic  p_cr   = 1'b0;
  logic  c_cr;
  logic  p_vld;
  data_t p_data;
  ptr_t  usage;

  int reset_cycles = 0;

  // Traffic model state
  logic [15:0] lfsr = 16'd11;
  int held        = 0;
  int n_sent      = 0;
  int dn_out      = 0;
  int grants_done = 0;

  // Sequence controls, written only by the main sequence
  logic up_en      = 1'b0;
  int   send_limit = 0;
  int   dn_mode    = DN_OFF;
  int   grants_req = 0;

  // Counters kept by the compare process
  int cr_rcvd   = 0;
  int words_in  = 0;
  int words_out = 0;
  int granted   = 0;

  vc_fifo i_vc_fifo (
    .clk    (clk),
    .reset  (reset),
    .c_vld  (c_vld),
    .c_data (c_data),
    .p_cr   (p_cr),
    .c_cr   (c_cr),
    .p_vld  (p_vld),
    .p_data (p_data),
    .usage  (usage)
  );

  initial
  begin
    forever
    begin
      #5 clk = ~clk;
    end
  end

  // Reset seen high at the first 8 rising edges
  always @(posedge clk)
  begin
    if (reset_cycles < 8)
    begin
      reset_cycles <= reset_cycles + 1;
    end
    if (reset_cycles == 7)
    begin
      reset <= 1'b0;
    end
  end

  // --------------------
  // Helpers
  // --------------------

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0])
    begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  // Word n of the stream, a fixed mix so that a lost or swapped word shows
  function automatic data_t expected_word(input int n);
    int mix;
    mix = n * 37 + 91;
    mix = mix ^ (n >> 3);
    return data_t'(mix);
  endfunction

  function automatic int count_of(input int sel);
    case (sel)
      SEL_SENT:     return n_sent;
      SEL_RECEIVED: return words_out;
      default:      return int'(usage);
    endcase
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual)
    begin
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "stopping after a failed check");
    end
  endtask

  task automatic wait_for_count(input string what, input int sel, input int target);
    int cycles;
    cycles = 0;
    while (count_of(sel) != target && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (count_of(sel) != target)
    begin
      $display("Timeout: the %s count did not reach %0d within %0d cycles",
               what, target, WAIT_LIMIT);
      $display("*** FAILED ***");
      $fatal(1, "stopping after a timeout");
    end
  endtask

  // Nothing may move on the data path for a while
  task automatic observe_quiet(input string name, input int exp_out, input int exp_usage,
                               input bit cr_low);
    int k;
    int sent_before;
    sent_before = n_sent;
    for (k = 0; k < QUIET_LEN; k++)
    begin
      @(negedge clk);
      check_value({name, " sent"}, sent_before, n_sent);
      check_value({name, " received"}, exp_out, words_out);
      check_value({name, " usage"}, exp_usage, int'(usage));
      check_value({name, " p_vld"}, 0, int'(p_vld));
      if (cr_low)
      begin
        check_value({name, " c_cr"}, 0, int'(c_cr));
      end
    end
  endtask

  // --------------------
  // Upstream and downstream models
  // --------------------
  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (c_cr)
      begin
        held = held + 1;
      end
      c_vld <= 1'b0;
      if (up_en && held > 0 && n_sent < send_limit)
      begin
        lfsr = lfsr_step(lfsr);
        if (lfsr[0])
        begin
          c_vld  <= 1'b1;
          c_data <= expected_word(n_sent);
          n_sent = n_sent + 1;
          held   = held - 1;
        end
      end

      if (p_vld)
      begin
        dn_out = dn_out - 1;
      end
      p_cr <= 1'b0;
      if (dn_out < `VC_MAX_CREDITS)
      begin
        if (dn_mode == DN_RANDOM)
        begin
          lfsr = lfsr_step(lfsr);
          if (lfsr[0])
          begin
            p_cr <= 1'b1;
            dn_out = dn_out + 1;
          end
        end
        else if (dn_mode == DN_COUNTED && grants_done < grants_req)
        begin
          p_cr <= 1'b1;
          dn_out      = dn_out + 1;
          grants_done = grants_done + 1;
        end
      end
    end
  end

  // --------------------
  // Compare process
  // --------------------
  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (p_vld)
      begin
        check_value("ordering", int'(expected_word(words_out)), int'(p_data));
        words_out = words_out + 1;
        // Grant at this edge cannot have paid for this word yet
        check_value("downstream credits", (words_out > granted) ? granted : words_out,
                    words_out);
      end
      if (p_cr)
      begin
        granted = granted + 1;
      end
      if (c_cr)
      begin
        cr_rcvd = cr_rcvd + 1;
      end
      if (c_vld)
      begin
        words_in = words_in + 1;
      end
      // Credits on hand upstream plus words inside the FIFO
      check_value("credit limit",
                  ((cr_rcvd - words_out) > `VC_DEPTH - 1) ? `VC_DEPTH - 1 : cr_rcvd - words_out,
                  (cr_rcvd - words_in) + (words_in - words_out));
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial
  begin
    int i;
    for (i = 0; i < 8; i++)
    begin
      @(negedge clk);
      check_value("reset c_cr", 0, int'(c_cr));
      check_value("reset p_vld", 0, int'(p_vld));
      check_value("reset usage", 0, int'(usage));
    end

    // Fill with no downstream credits until the head stops granting
    send_limit = 1000;
    up_en      = 1'b1;
    wait_for_count("usage", SEL_USAGE, `VC_DEPTH - 1);
    check_value("back-pressure usage", n_sent, int'(usage));
    observe_quiet("back-pressure", 0, `VC_DEPTH - 1, 1'b1);

    // Exactly k credits to the full FIFO
    up_en      = 1'b0;
    dn_mode    = DN_COUNTED;
    grants_req = GRANT_WORDS;
    wait_for_count("received", SEL_RECEIVED, GRANT_WORDS);
    observe_quiet("credit grant", GRANT_WORDS, `VC_DEPTH - 1 - GRANT_WORDS, 1'b0);

    // Random traffic on both sides
    dn_mode    = DN_RANDOM;
    send_limit = n_sent + ORDER_WORDS;
    up_en      = 1'b1;
    wait_for_count("sent", SEL_SENT, send_limit);

    // Upstream is done, downstream keeps granting until empty
    wait_for_count("received", SEL_RECEIVED, send_limit);
    wait_for_count("usage", SEL_USAGE, 0);
    up_en   = 1'b0;
    dn_mode = DN_OFF;
    observe_quiet("drain", n_sent, 0, 1'b0);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/vc_pkg.sv
rtl/vc_fifo_head.sv
rtl/vc_fifo_mem.sv
rtl/vc_fifo_tail.sv
rtl/vc_fifo.sv
sim/vc_fifo_properties.sv
sim/tb_vc_fifo.sv

//--- run.sh
#!/bin/sh
# Compile the valid/credit FIFO testbench with Verilator and run it
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -j 0 \
       --top-module tb_vc_fifo -f project.f -o sim_vc_fifo \
  && ./obj_dir/sim_vc_fifo \
  || { echo "Simulation did not complete successfully"; exit 1; }
